// File: hw/lc3_control.sv
module lc3_control import lc3_pkg::*; (
    input  logic  LC3_vif,
    input  logic  rst_n,
    input  word_t instr_dout,
    input  logic  branch_taken,
    output word_t ir,
    output logic  instrmem_rd,
    output logic  pc_inc,
    output logic  pc_load,
    output logic  rf_we,
    output logic  cc_we,
    output logic  ptr_load,
    output logic  mem_rd,
    output logic  mem_wr
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_ADDRESS,   // Single data access at ea
        S_INDIRECT,  // Pointer read at ea
        S_ACCESS,    // Data access through the pointer
        S_REDIRECT   // PC update of BR and JMP
    } state_t;

    state_t  state;
    state_t  state_nxt;
    logic    started;     // Low in the first cycle after reset
    logic    wb_pending;  // ALU or LEA in ir awaits its write-back
    opcode_t fetch_op;
    opcode_t ir_op;

    assign fetch_op    = get_opcode(instr_dout);
    assign ir_op       = get_opcode(ir);
    assign instrmem_rd = started && (state == S_FETCH);
    assign cc_we       = rf_we;  // Every register write sets n/z/p

    //////////////////////////////////////////////////
    // State and instruction register

    always_ff @(posedge LC3_vif or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_FETCH;
            started    <= 1'b0;
            wb_pending <= 1'b0;
            ir         <= NOP_WORD;
        end else begin
            state      <= state_nxt;
            started    <= 1'b1;
            wb_pending <= instrmem_rd && (fetch_op inside {OP_ADD, OP_AND, OP_NOT, OP_LEA});
            if (instrmem_rd) begin
                ir <= instr_dout;
            end
        end
    end

    //////////////////////////////////////////////////
    // Next state and strobes

    always_comb begin
        state_nxt = S_FETCH;
        pc_inc    = 1'b0;
        pc_load   = 1'b0;
        rf_we     = 1'b0;
        ptr_load  = 1'b0;
        mem_rd    = 1'b0;
        mem_wr    = 1'b0;
        case (state)
            S_FETCH: begin
                rf_we = wb_pending;  // Retire the previous ALU op
                if (started) begin
                    case (fetch_op)
                        OP_LD, OP_LDR, OP_ST, OP_STR: state_nxt = S_ADDRESS;
                        OP_LDI, OP_STI:               state_nxt = S_INDIRECT;
                        OP_BR, OP_JMP:                state_nxt = S_REDIRECT;
                        default:                      state_nxt = S_FETCH;
                    endcase
                    pc_inc = !(fetch_op inside {OP_BR, OP_JMP});  // Branches hold PC
                end
            end
            S_ADDRESS: begin
                mem_rd = ir_op inside {OP_LD, OP_LDR};
                mem_wr = ir_op inside {OP_ST, OP_STR};
                rf_we  = mem_rd;
            end
            S_INDIRECT: begin
                state_nxt = S_ACCESS;
                mem_rd    = 1'b1;
                ptr_load  = 1'b1;
            end
            S_ACCESS: begin
                mem_rd = (ir_op == OP_LDI);
                mem_wr = (ir_op == OP_STI);
                rf_we  = mem_rd;
            end
            S_REDIRECT: begin
                pc_load = branch_taken;
                pc_inc  = !branch_taken;
            end
            default: state_nxt = S_FETCH;
        endcase
    end

    // One data direction per cycle
    assert property (@(posedge LC3_vif) disable iff (!rst_n) !(mem_rd && mem_wr));

endmodule

// File: hw/lc3_core.sv
module lc3_core import lc3_pkg::*; #(
    parameter word_t RESET_PC = 16'h3000
) (
    input  logic  LC3_vif,
    input  logic  rst_n,
    input  word_t instr_dout,
    input  word_t data_dout,
    output word_t pc,
    output logic  instrmem_rd,
    output word_t data_addr,
    output word_t data_din,
    output logic  data_rd,
    output logic  data_wr
);

    word_t    ir;
    logic     pc_inc;
    logic     pc_load;
    logic     rf_we;
    logic     cc_we;
    logic     ptr_load;
    logic     mem_rd;
    logic     mem_wr;
    logic     branch_taken;
    word_t    ea;
    word_t    target;
    word_t    wr_data;
    word_t    a;
    word_t    b;
    reg_idx_t rd_b_idx;

    // Stores read their source through port b
    assign rd_b_idx = (get_opcode(ir) inside {OP_ST, OP_STR, OP_STI}) ?
                      ir[DR_LSB +: 3] : ir[SR2_LSB +: 3];

    lc3_control u_control (
        .LC3_vif      (LC3_vif),
        .rst_n        (rst_n),
        .instr_dout   (instr_dout),
        .branch_taken (branch_taken),
        .ir           (ir),
        .instrmem_rd  (instrmem_rd),
        .pc_inc       (pc_inc),
        .pc_load      (pc_load),
        .rf_we        (rf_we),
        .cc_we        (cc_we),
        .ptr_load     (ptr_load),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr)
    );

    lc3_pc #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .LC3_vif (LC3_vif),
        .rst_n   (rst_n),
        .pc_inc  (pc_inc),
        .pc_load (pc_load),
        .target  (target),
        .pc      (pc)
    );

    lc3_regfile u_regfile (
        .LC3_vif (LC3_vif),
        .rst_n   (rst_n),
        .rd_a    (ir[SR1_LSB +: 3]),
        .rd_b    (rd_b_idx),
        .wr_idx  (ir[DR_LSB +: 3]),
        .we      (rf_we),
        .wr_data (wr_data),
        .a       (a),
        .b       (b)
    );

    lc3_execute u_execute (
        .LC3_vif      (LC3_vif),
        .rst_n        (rst_n),
        .ir           (ir),
        .pc           (pc),
        .a            (a),
        .b            (b),
        .data_dout    (data_dout),
        .cc_we        (cc_we),
        .ea           (ea),
        .target       (target),
        .wr_data      (wr_data),
        .branch_taken (branch_taken)
    );

    lc3_mem_port u_mem_port (
        .LC3_vif   (LC3_vif),
        .rst_n     (rst_n),
        .ea        (ea),
        .src       (b),
        .data_dout (data_dout),
        .ptr_load  (ptr_load),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .data_addr (data_addr),
        .data_din  (data_din),
        .data_rd   (data_rd),
        .data_wr   (data_wr)
    );

endmodule

// File: hw/lc3_execute.sv
module lc3_execute import lc3_pkg::*; (
    input  logic  LC3_vif,
    input  logic  rst_n,
    input  word_t ir,
    input  word_t pc,
    input  word_t a,
    input  word_t b,
    input  word_t data_dout,
    input  logic  cc_we,
    output word_t ea,
    output word_t target,
    output word_t wr_data,
    output logic  branch_taken
);

    opcode_t op;
    word_t   imm5;
    word_t   off6;
    word_t   off9;
    word_t   operand;
    word_t   pc_base;
    word_t   alu_out;
    cc_t     cc;

    assign op = get_opcode(ir);

    // Sign-extended immediates
    assign imm5 = {{11{ir[4]}}, ir[4:0]};
    assign off6 = {{10{ir[5]}}, ir[5:0]};
    assign off9 = {{7{ir[8]}}, ir[8:0]};

    assign operand = ir[IMM_SEL] ? imm5 : b;

    //////////////////////////////////////////////////
    // Addresses

    // BR keeps pc on its own address until redirect
    assign pc_base = (op == OP_BR) ? pc + 16'd1 : pc;
    assign ea      = (op inside {OP_LDR, OP_STR}) ? a + off6 : pc_base + off9;
    assign target  = (op == OP_JMP) ? a : ea;

    //////////////////////////////////////////////////
    // ALU and write-back select

    always_comb begin
        case (op)
            OP_AND:  alu_out = a & operand;
            OP_NOT:  alu_out = ~a;
            default: alu_out = a + operand;
        endcase
    end

    always_comb begin
        case (op)
            OP_LEA:                 wr_data = ea;
            OP_LD, OP_LDR, OP_LDI:  wr_data = data_dout;
            default:                wr_data = alu_out;
        endcase
    end

    //////////////////////////////////////////////////
    // Condition codes

    always_ff @(posedge LC3_vif or negedge rst_n) begin
        if (!rst_n) begin
            cc <= CC_Z;
        end else if (cc_we) begin
            if (wr_data[15]) begin
                cc <= CC_N;
            end else if (wr_data == '0) begin
                cc <= CC_Z;
            end else begin
                cc <= CC_P;
            end
        end
    end

    // JMP is always taken, BR only on a matching code
    assign branch_taken = (op == OP_BR) ? |(ir[DR_LSB +: 3] & cc) : (op == OP_JMP);

endmodule

// File: hw/lc3_mem_port.sv
module lc3_mem_port import lc3_pkg::*; (
    input  logic  LC3_vif,
    input  logic  rst_n,
    input  word_t ea,
    input  word_t src,
    input  word_t data_dout,
    input  logic  ptr_load,
    input  logic  mem_rd,
    input  logic  mem_wr,
    output word_t data_addr,
    output word_t data_din,
    output logic  data_rd,
    output logic  data_wr
);

    word_t ptr;        // Pointer fetched by LDI/STI
    logic  ptr_valid;  // Next access goes through ptr

    //////////////////////////////////////////////////
    // Indirect pointer

    always_ff @(posedge LC3_vif) begin
        if (ptr_load) begin
            ptr <= data_dout;
        end
    end

    always_ff @(posedge LC3_vif or negedge rst_n) begin
        if (!rst_n) begin
            ptr_valid <= 1'b0;
        end else if (ptr_load) begin
            ptr_valid <= 1'b1;
        end else if (mem_rd || mem_wr) begin
            ptr_valid <= 1'b0;  // Used up by the second access
        end
    end

    //////////////////////////////////////////////////
    // Bus drive

    assign data_addr = ptr_valid ? ptr : ea;
    assign data_din  = src;
    assign data_rd   = mem_rd;
    assign data_wr   = mem_wr;

    // Store address seen at mid-cycle still holds at the closing edge
    assert property (@(edge LC3_vif) disable iff (!rst_n)
        (LC3_vif && data_wr) |=> $stable(data_addr));

endmodule

// File: hw/lc3_pc.sv
module lc3_pc import lc3_pkg::*; #(
    parameter word_t RESET_PC = 16'h3000
) (
    input  logic  LC3_vif,
    input  logic  rst_n,
    input  logic  pc_inc,
    input  logic  pc_load,
    input  word_t target,
    output word_t pc
);

    word_t pc_nxt;

    // Branch or jump target wins over the increment
    always_comb begin
        pc_nxt = pc;
        if (pc_load) begin
            pc_nxt = target;
        end else if (pc_inc) begin
            pc_nxt = pc + 16'd1;
        end
    end

    always_ff @(posedge LC3_vif or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_nxt;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    // Control never asks for both updates in one cycle
    assert property (@(posedge LC3_vif) disable iff (!rst_n) !(pc_inc && pc_load));

endmodule

// File: hw/lc3_pkg.sv
package lc3_pkg;

    //////////////////////////////////////////////////
    // Basic data types

    typedef logic [15:0] word_t;     // One memory or register word
    typedef logic [2:0]  reg_idx_t;  // R0 .. R7
    typedef logic [2:0]  cc_t;       // {n, z, p}

    //////////////////////////////////////////////////
    // Opcodes in the top nibble of the instruction word

    typedef enum logic [3:0] {
        OP_BR  = 4'b0000,
        OP_ADD = 4'b0001,
        OP_LD  = 4'b0010,
        OP_ST  = 4'b0011,
        OP_AND = 4'b0101,
        OP_LDR = 4'b0110,
        OP_STR = 4'b0111,
        OP_NOT = 4'b1001,
        OP_LDI = 4'b1010,
        OP_STI = 4'b1011,
        OP_JMP = 4'b1100,
        OP_LEA = 4'b1110
    } opcode_t;  // JSR, TRAP, RTI and 1101 are left out

    //////////////////////////////////////////////////
    // Instruction field positions

    localparam int OPC_LSB = 12;  // Opcode nibble
    localparam int DR_LSB  = 9;   // DR, SR of stores, nzp mask of BR
    localparam int SR1_LSB = 6;   // SR1 and BaseR
    localparam int SR2_LSB = 0;   // SR2 in register form
    localparam int IMM_SEL = 5;   // Set for the imm5 form of ADD/AND

    // Condition code values
    localparam cc_t CC_N = 3'b100;
    localparam cc_t CC_Z = 3'b010;
    localparam cc_t CC_P = 3'b001;

    localparam word_t NOP_WORD = 16'h5020;  // AND R0, R0, #0

    function automatic opcode_t get_opcode(word_t instr);
        return opcode_t'(instr[OPC_LSB +: 4]);
    endfunction

endpackage

// File: hw/lc3_regfile.sv
module lc3_regfile import lc3_pkg::*; (
    input  logic     LC3_vif,
    input  logic     rst_n,
    input  reg_idx_t rd_a,
    input  reg_idx_t rd_b,
    input  reg_idx_t wr_idx,
    input  logic     we,
    input  word_t    wr_data,
    output word_t    a,
    output word_t    b
);

    localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

    word_t regs [NUM_REGS];

    always_ff @(posedge LC3_vif or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Read ports see the old value during a write cycle
    assign a = regs[rd_a];
    assign b = regs[rd_b];

    // Write-back data traces back to memory or the ALU
    assert property (@(posedge LC3_vif) disable iff (!rst_n) we |-> !$isunknown(wr_data));

endmodule

// File: src.f
hw/lc3_pkg.sv
hw/lc3_control.sv
hw/lc3_pc.sv
hw/lc3_regfile.sv
hw/lc3_execute.sv
hw/lc3_mem_port.sv
hw/lc3_core.sv
testbench/lc3_tb.sv

// File: testbench/lc3_tb.sv
module lc3_tb import lc3_pkg::*; ();

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 5;
    localparam word_t START_PC     = 16'h3000;

    logic  LC3_vif;
    logic  rst_n;
    word_t instr_dout;
    word_t data_dout;
    word_t pc;
    logic  instrmem_rd;
    word_t data_addr;
    word_t data_din;
    logic  data_rd;
    logic  data_wr;

    word_t imem [65536];  // Instruction memory model
    word_t dmem [65536];  // Data memory model

    //////////////////////////////////////////////////
    // Test file contents

    logic [255:0] name_q [$];
    int           fetch_q [$];    // Fetch strobes to run
    word_t        last_q [$];     // Address of the last fetch
    int           init_test [$];
    bit           init_data [$];  // Set for data memory, clear for instructions
    word_t        init_addr [$];
    word_t        init_val [$];
    int           exp_test [$];
    word_t        exp_addr [$];
    word_t        exp_val [$];

    word_t log_addr [$];  // Stores seen on the data bus
    word_t log_val [$];
    int    cur_test;
    int    fetch_count;
    int    fetch_target;
    int    read_count;
    int    exp_reads;
    word_t last_fetch;
    bit    wr_pend;
    word_t wr_addr;
    word_t wr_val;
    int    errors;
    int    failed;
    bit    parsed;

    lc3_core dut (
        .LC3_vif     (LC3_vif),
        .rst_n       (rst_n),
        .instr_dout  (instr_dout),
        .data_dout   (data_dout),
        .pc          (pc),
        .instrmem_rd (instrmem_rd),
        .data_addr   (data_addr),
        .data_din    (data_din),
        .data_rd     (data_rd),
        .data_wr     (data_wr)
    );

    always #(CLK_PERIOD / 2) LC3_vif = ~LC3_vif;

    task automatic compare_word(input string sig, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %0s in test %0s: got %h, expected %h",
                     sig, name_q[cur_test], got, exp);
            errors++;
        end
    endtask

    // Data reads that one instruction makes under the ISA
    function automatic int expected_reads(input word_t instr);
        case (instr[15:12])
            4'b0010, 4'b0110, 4'b1011: return 1;  // LD, LDR, STI pointer
            4'b1010:                   return 2;  // LDI pointer and data
            default:                   return 0;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Memory models and bus monitor

    always @(negedge LC3_vif) begin
        if (fetch_count < fetch_target) begin
            if (instrmem_rd) begin
                if (fetch_count == 0) begin
                    compare_word("pc", pc, START_PC);  // First fetch after reset
                end
                // The last fetched instruction is not run to its end
                if (fetch_count + 1 < fetch_target) begin
                    exp_reads = exp_reads + expected_reads(imem[pc]);
                end
                last_fetch  = pc;
                fetch_count = fetch_count + 1;
            end
            if (data_rd) begin
                read_count = read_count + 1;
            end
            wr_pend = data_wr;  // Committed at the closing edge
            wr_addr = data_addr;
            wr_val  = data_din;
        end
        instr_dout <= imem[pc];
        data_dout  <= dmem[data_addr];
    end

    always @(posedge LC3_vif) begin
        if (!rst_n && (instrmem_rd || data_rd || data_wr)) begin
            $display("a memory strobe was high during reset in test %0s", name_q[cur_test]);
            errors++;
        end
        if (wr_pend) begin
            dmem[wr_addr] = wr_val;
            log_addr.push_back(wr_addr);
            log_val.push_back(wr_val);
            wr_pend = 1'b0;
        end
    end

    task automatic read_tests(input int fd);
        logic [255:0]  tok;
        logic [1023:0] line;
        word_t         addr;
        word_t         val;
        int            n;
        int            code;
        tok  = '0;
        code = $fscanf(fd, "%s", tok);
        while (code == 1) begin
            if (tok == "#") begin
                code = $fgets(line, fd);
            end else if (tok == "test") begin
                tok  = '0;
                code = $fscanf(fd, "%s %d %h", tok, n, addr);
                name_q.push_back(tok);
                fetch_q.push_back(n);
                last_q.push_back(addr);
            end else if (tok == "i" || tok == "d") begin
                code = $fscanf(fd, "%h %d", addr, n);
                for (int k = 0; k < n; k++) begin
                    code = $fscanf(fd, "%h", val);
                    init_test.push_back(name_q.size() - 1);
                    init_data.push_back(tok == "d");
                    init_addr.push_back(word_t'(addr + k));
                    init_val.push_back(val);
                end
            end else if (tok == "s") begin
                code = $fscanf(fd, "%d", n);
                for (int k = 0; k < n; k++) begin
                    code = $fscanf(fd, "%h %h", addr, val);
                    exp_test.push_back(name_q.size() - 1);
                    exp_addr.push_back(addr);
                    exp_val.push_back(val);
                end
            end else begin
                $display("unknown keyword %0s in the test file", tok);
                errors++;
            end
            tok  = '0;
            code = $fscanf(fd, "%s", tok);
        end
    endtask

    task automatic load_memories(input int t);
        for (int a = 0; a < 65536; a++) begin
            imem[a] = {7'b0, a[8:0] ^ {2'b0, a[15:9]}};  // Never-taken BR
            dmem[a] = word_t'(a) ^ 16'h5a3c;
        end
        foreach (init_test[k]) begin
            if (init_test[k] == t) begin
                if (init_data[k]) begin
                    dmem[init_addr[k]] = init_val[k];
                end else begin
                    imem[init_addr[k]] = init_val[k];
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    task automatic run_test(input int t);
        int first_err;
        int n;
        first_err = errors;
        cur_test  = t;
        @(negedge LC3_vif);
        rst_n = 1'b0;  // Lands mid-program after the first test
        load_memories(t);
        log_addr.delete();
        log_val.delete();
        repeat (RESET_CYCLES) @(negedge LC3_vif);
        fetch_count  = 0;
        fetch_target = fetch_q[t];
        read_count   = 0;
        exp_reads    = 0;
        rst_n        = 1'b1;
        wait (fetch_count == fetch_target);
        compare_word("pc", last_fetch, last_q[t]);
        n = 0;
        foreach (exp_test[k]) begin
            if (exp_test[k] == t) begin
                if (n < log_addr.size()) begin
                    compare_word("data_addr", log_addr[n], exp_addr[k]);
                    compare_word("data_din", log_val[n], exp_val[k]);
                end
                n++;
            end
        end
        compare_word("data_wr count", word_t'(log_addr.size()), word_t'(n));
        compare_word("data_rd count", word_t'(read_count), word_t'(exp_reads));
        if (errors == first_err) begin
            $display("test %0s: ok", name_q[t]);
        end else begin
            $display("test %0s: %0d errors", name_q[t], errors - first_err);
            failed++;
        end
    endtask

    initial begin
        int fd;
        LC3_vif      = 1'b0;
        rst_n        = 1'b0;
        instr_dout   = NOP_WORD;
        data_dout    = '0;
        errors       = 0;
        failed       = 0;
        cur_test     = 0;
        fetch_count  = 0;
        fetch_target = 0;
        read_count   = 0;
        exp_reads    = 0;
        last_fetch   = '0;
        wr_pend      = 1'b0;
        parsed       = 1'b0;
        fd = $fopen("testbench/lc3_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/lc3_tests.txt");
            $display("*** FAILED ***");
            $finish;
        end else begin
            read_tests(fd);
            $fclose(fd);
            parsed = 1'b1;
            if (name_q.size() == 0) begin
                $display("no tests found in the test file");
                errors++;
            end
            for (int t = 0; t < name_q.size(); t++) begin
                run_test(t);
            end
            $display("%0d tests run, %0d failed, %0d errors", name_q.size(), failed, errors);
            if (errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

    // Watchdog allows three cycles per fetch plus reset, doubled
    initial begin
        int cycles;
        wait (parsed);
        cycles = 0;
        foreach (fetch_q[t]) begin
            cycles += 3 * fetch_q[t] + RESET_CYCLES + 2;
        end
        #(2 * cycles * CLK_PERIOD);
        $display("timeout: test %0s reached only %0d of %0d fetches",
                 name_q[cur_test], fetch_count, fetch_target);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: testbench/lc3_tests.txt
# test <name> <fetches to run> <pc of last fetch> | i or d <start addr> <count> <words>
# s <count> then <addr> <value> per expected store, in order | counts decimal, rest hex
test reset_alu 14 300b
i 3000 12 1225 147d 1642 58e6 9aff 5d41 3619 3a19 ee20 79c1 7dfe 0fff
s 4 3020 0007 3021 fff8 302a 0006 3027 0000

test loads 10 3008
i 3000 9 223f a43f e64d 68c2 72c0 74c1 76c3 78c4 0fff
d 3040 2 1234 4000
d 4000 1 beef
d 3052 1 00a5
s 4 3050 1234 3051 beef 3053 3050 3054 00a5

test indirect_store 8 3006
i 3000 7 5260 1279 b22d a42c 16a1 b62b 0fff
d 3030 2 5000 5001
s 2 5000 fff9 5001 fffa

test branches 11 300d
i 3000 14 5260 0401 323d 147f 0801 343a 1663 0c05 3638 0202 343a 343a 3435 0fff
s 2 3041 0003 3042 ffff

test jmp 8 3023
i 3000 4 e81f 1229 c100 323c
i 3020 4 323f 947f 7501 0fff
s 2 3060 0009 3021 fff6

test countdown 13 3005
i 3000 6 5260 1263 323d 127f 03fd 0fff
s 3 3040 0003 3040 0002 3040 0001
